/* rtl/icache_geom_pkg.sv */
package icache_geom_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int NUM_SETS       = 64;
    localparam int WORDS_PER_LINE = 16;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;

    // Field widths follow from the line size and the number of sets.
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;   // Bits 5 to 2 pick the word.
    typedef logic [TAG_BITS-1:0]    tag_t;

    function automatic offset_t addr_offset(addr_t addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

endpackage

/* rtl/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // A line address is the tag followed by the set index.
    localparam int LINE_ADDR_BITS = $bits(icache_geom_pkg::tag_t)
                                  + $bits(icache_geom_pkg::index_t);

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    typedef enum logic [2:0]
    {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        REPLAY
    } ctrl_state_t;

    function automatic line_addr_t line_addr_of(icache_geom_pkg::addr_t addr);
        return {icache_geom_pkg::addr_tag(addr), icache_geom_pkg::addr_index(addr)};
    endfunction

endpackage

/* rtl/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array
(
    input  logic                     clk,
    input  logic                     nrst,
    input  icache_geom_pkg::index_t  index,
    input  icache_geom_pkg::offset_t offset,
    input  logic                     refill,
    input  icache_geom_pkg::line_t   refill_line,
    output icache_geom_pkg::word_t   rd_word
);

    import icache_geom_pkg::*;

    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);

    line_t                    lines [NUM_SETS];
    logic [WORD_SEL_BITS-1:0] word_sel;

    assign word_sel = offset[2 +: WORD_SEL_BITS];   // Byte offset drops the low two bits.

    // Whole-line refill from L2.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < NUM_SETS; i++)
            begin
                lines[i] <= '0;
            end
        end
        else if (refill)
        begin
            lines[index] <= refill_line;
        end
    end

    // The read sees the line as it was before a refill in the same cycle.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_word <= '0;
        end
        else
        begin
            rd_word <= lines[index][word_sel * WORD_BITS +: WORD_BITS];
        end
    end

endmodule

/* rtl/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array
(
    input  logic                    clk,
    input  logic                    nrst,
    input  icache_geom_pkg::index_t index,
    input  logic                    refill,
    input  icache_geom_pkg::tag_t   tag_wdata,
    input  logic                    flush,
    output logic                    rd_valid,
    output icache_geom_pkg::tag_t   rd_tag
);

    import icache_geom_pkg::*;

    logic [NUM_SETS-1:0] valid;
    tag_t                tags [NUM_SETS];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
        end
        else if (flush)
        begin
            valid <= '0;   // Flash invalidate of every set.
        end
        else if (refill)
        begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            tags[index] <= tag_wdata;
        end
    end

    // A fetch taken together with a flush must already see the lines invalid.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_valid <= 1'b0;
            rd_tag   <= '0;
        end
        else
        begin
            rd_valid <= valid[index] && !flush;
            rd_tag   <= tags[index];
        end
    end

    // The controller holds a flush back while a refill is outstanding.
    refill_flush_exclusive: assert property (
        @(posedge clk) disable iff (!nrst)
        !(refill && flush)
    ) else $error("Refill and flush in the same cycle.");

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
(
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         fetch_req,
    input  icache_geom_pkg::addr_t       fetch_addr,
    input  logic                         flush_in,
    input  logic                         rd_valid,
    input  icache_geom_pkg::tag_t        rd_tag,
    input  icache_geom_pkg::word_t       rd_word,
    input  logic                         l2_valid,
    output logic                         fetch_valid,
    output icache_geom_pkg::word_t       fetch_data,
    output logic                         l2_req,
    output icache_ctrl_pkg::line_addr_t  l2_line_addr,
    output icache_geom_pkg::index_t      index,
    output icache_geom_pkg::offset_t     offset,
    output logic                         refill,
    output icache_geom_pkg::tag_t        tag_wdata,
    output logic                         flush_out
);

    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    addr_t       held_addr;
    logic        tag_match;
    logic        accept;
    logic        busy;
    logic        flush_pend;

    // The arrays answer one cycle after the address, so the compare uses the held tag.
    assign tag_match = rd_valid && (rd_tag == addr_tag(held_addr));

    assign accept = fetch_req && ((state == IDLE) || (state == LOOKUP && tag_match));

    assign busy = (state == MISS_REQ) || (state == MISS_WAIT) || (state == REPLAY);

    // Set index mux. A new fetch goes straight to the arrays, otherwise the held one.
    always_comb
    begin
        if (accept)
        begin
            index  = addr_index(fetch_addr);
            offset = addr_offset(fetch_addr);
        end
        else
        begin
            index  = addr_index(held_addr);
            offset = addr_offset(held_addr);
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (accept)
                begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (!tag_match)
                begin
                    state_next = MISS_REQ;
                end
                else if (!accept)
                begin
                    state_next = IDLE;
                end
            end
            MISS_REQ:  state_next = MISS_WAIT;
            MISS_WAIT:
            begin
                if (l2_valid)
                begin
                    state_next = REPLAY;
                end
            end
            REPLAY:    state_next = LOOKUP;   // Re-read the refilled line.
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            held_addr <= '0;
        end
        else if (accept)
        begin
            held_addr <= fetch_addr;
        end
    end

    // A flush seen during a miss waits until the replayed fetch has been answered.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            flush_pend <= 1'b0;
        end
        else if (flush_out)
        begin
            flush_pend <= 1'b0;
        end
        else if (flush_in && busy)
        begin
            flush_pend <= 1'b1;
        end
    end

    assign flush_out = !busy && (flush_in || flush_pend);

    assign fetch_valid  = (state == LOOKUP) && tag_match;
    assign fetch_data   = rd_word;
    assign l2_req       = (state == MISS_REQ);
    assign l2_line_addr = line_addr_of(held_addr);
    assign refill       = (state == MISS_WAIT) && l2_valid;
    assign tag_wdata    = addr_tag(held_addr);

    // There is no back-pressure, so the fetch unit must only issue when the cache can take it.
    fetch_only_when_accepting: assert property (
        @(posedge clk) disable iff (!nrst)
        fetch_req |-> (state == IDLE) || (state == LOOKUP && tag_match)
    ) else $error("Fetch request while the cache is busy.");

    l2_valid_only_in_wait: assert property (
        @(posedge clk) disable iff (!nrst)
        l2_valid |-> state == MISS_WAIT
    ) else $error("L2 line returned with no request outstanding.");

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top
(
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        fetch_req,
    input  icache_geom_pkg::addr_t      fetch_addr,
    input  logic                        flush,
    input  logic                        l2_valid,
    input  icache_geom_pkg::line_t      l2_line,
    output logic                        fetch_valid,
    output icache_geom_pkg::word_t      fetch_data,
    output logic                        l2_req,
    output icache_ctrl_pkg::line_addr_t l2_line_addr
);

    import icache_geom_pkg::*;

    index_t  index;
    offset_t offset;
    logic    refill;
    tag_t    tag_wdata;
    logic    flush_arr;
    logic    rd_valid;
    tag_t    rd_tag;
    word_t   rd_word;

    icache_ctrl u_ctrl
    (
        .clk          (clk),
        .nrst         (nrst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .flush_in     (flush),
        .rd_valid     (rd_valid),
        .rd_tag       (rd_tag),
        .rd_word      (rd_word),
        .l2_valid     (l2_valid),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .l2_req       (l2_req),
        .l2_line_addr (l2_line_addr),
        .index        (index),
        .offset       (offset),
        .refill       (refill),
        .tag_wdata    (tag_wdata),
        .flush_out    (flush_arr)
    );

    icache_tag_array u_tag_array
    (
        .clk       (clk),
        .nrst      (nrst),
        .index     (index),
        .refill    (refill),
        .tag_wdata (tag_wdata),
        .flush     (flush_arr),
        .rd_valid  (rd_valid),
        .rd_tag    (rd_tag)
    );

    // The L2 line goes into the data array unchanged.
    icache_data_array u_data_array
    (
        .clk         (clk),
        .nrst        (nrst),
        .index       (index),
        .offset      (offset),
        .refill      (refill),
        .refill_line (l2_line),
        .rd_word     (rd_word)
    );

endmodule

/* dv/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int    PERIOD        = 8;
    localparam int    SEED          = 12916;
    localparam word_t PATTERN_KEY   = 32'h5A3C_C3A5;
    localparam int    NUM_FETCHES   = 32;
    localparam int    MISS_CYCLES   = 16;   // Lookup, request, up to 8 L2 cycles, refill, replay.
    localparam int    MARGIN_CYCLES = 100;
    localparam int    TIMEOUT_NS    = (NUM_FETCHES * MISS_CYCLES + MARGIN_CYCLES) * PERIOD;

    logic       clk;
    logic       nrst;
    logic       fetch_req;
    addr_t      fetch_addr;
    logic       flush;
    logic       l2_valid;
    line_t      l2_line;
    logic       fetch_valid;
    word_t      fetch_data;
    logic       l2_req;
    line_addr_t l2_line_addr;

    logic       quiet;
    logic       expect_miss;
    logic       expect_hit;
    logic       resp_expected;
    word_t      exp_word;
    addr_t      resp_q [$];
    int         errors;
    int         errors_at_mark;
    int         test_count;

    icache_top uut
    (
        .clk          (clk),
        .nrst         (nrst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .flush        (flush),
        .l2_valid     (l2_valid),
        .l2_line      (l2_line),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .l2_req       (l2_req),
        .l2_line_addr (l2_line_addr)
    );

    // Every word of L2 holds its own word address mixed with a key.
    function automatic word_t word_pattern(addr_t addr);
        return {2'b00, addr[31:2]} ^ PATTERN_KEY;
    endfunction

    function automatic line_t line_pattern(line_addr_t line_addr);
        line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++)
        begin
            line[w*32 +: 32] = word_pattern({line_addr, 4'(w), 2'b00});
        end
        return line;
    endfunction

    function automatic line_addr_t expected_line(addr_t addr);
        return addr[31:6];
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // L2 answers each request after 1 to 8 cycles.
    initial
    begin : l2_model
        line_addr_t req_addr;
        int         delay;
        void'($urandom(SEED));
        l2_valid = 1'b0;
        l2_line  = '0;
        forever
        begin
            @(negedge clk);
            if (nrst && l2_req)
            begin
                req_addr = l2_line_addr;
                delay    = $urandom_range(8, 1);
                repeat (delay) @(posedge clk);
                l2_valid <= 1'b1;
                l2_line  <= line_pattern(req_addr);
                @(posedge clk);
                l2_valid <= 1'b0;
            end
        end
    end

    // The oldest outstanding fetch is the one the current response answers.
    always @(negedge clk)
    begin
        if (fetch_valid)
        begin
            resp_expected = (resp_q.size() > 0);
            if (resp_expected)
            begin
                exp_word = word_pattern(resp_q.pop_front());
            end
        end
    end

    quiet_after_reset: assert property (
        @(posedge clk) disable iff (!nrst)
        quiet |-> !fetch_valid && !l2_req
    ) else
    begin
        errors++;
        $display("Fail at %0t ns: activity on fetch_valid or l2_req with no fetch issued", $time);
    end

    response_matches: assert property (
        @(posedge clk) disable iff (!nrst)
        fetch_valid |-> resp_expected && fetch_data == exp_word
    ) else
    begin
        errors++;
        $display("Fail at %0t ns: fetch_data %h, expected %h", $time,
                 $sampled(fetch_data), exp_word);
    end

    miss_requests_line: assert property (
        @(posedge clk) disable iff (!nrst)
        fetch_req && expect_miss |-> ##1 !fetch_valid
            ##1 (l2_req && l2_line_addr == expected_line($past(fetch_addr, 2)))
    ) else
    begin
        errors++;
        $display("Fail at %0t ns: missing fetch gave no L2 request for the right line", $time);
    end

    l2_req_single: assert property (
        @(posedge clk) disable iff (!nrst)
        l2_req |=> !l2_req
    ) else
    begin
        errors++;
        $display("Fail at %0t ns: l2_req held for more than one cycle", $time);
    end

    hit_in_one_cycle: assert property (
        @(posedge clk) disable iff (!nrst)
        fetch_req && expect_hit |=> (fetch_valid && !l2_req) ##1 !l2_req
    ) else
    begin
        errors++;
        $display("Fail at %0t ns: resident line not answered one cycle after fetch", $time);
    end

    task automatic fetch_one(input addr_t addr, input bit miss);
        @(posedge clk);
        fetch_req   <= 1'b1;
        fetch_addr  <= addr;
        expect_miss <= miss;
        expect_hit  <= !miss;
        resp_q.push_back(addr);
        @(posedge clk);
        fetch_req   <= 1'b0;
        expect_miss <= 1'b0;
        expect_hit  <= 1'b0;
        while (resp_q.size() != 0) @(posedge clk);
    endtask

    // One fetch per cycle into a resident line.
    task automatic fetch_burst(input addr_t base, input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge clk);
            fetch_req  <= 1'b1;
            fetch_addr <= base + 4 * i;
            expect_hit <= 1'b1;
            resp_q.push_back(base + 4 * i);
        end
        @(posedge clk);
        fetch_req  <= 1'b0;
        expect_hit <= 1'b0;
        while (resp_q.size() != 0) @(posedge clk);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("Test %0d (%s) done with %0d errors.", test_count, name,
                 errors - errors_at_mark);
        errors_at_mark = errors;
    endtask

    initial
    begin : stimulus
        nrst           = 1'b0;
        fetch_req      = 1'b0;
        fetch_addr     = '0;
        flush          = 1'b0;
        quiet          = 1'b0;
        expect_miss    = 1'b0;
        expect_hit     = 1'b0;
        resp_expected  = 1'b0;
        exp_word       = '0;
        errors         = 0;
        errors_at_mark = 0;
        test_count     = 0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        quiet <= 1'b1;
        repeat (6) @(posedge clk);
        quiet <= 1'b0;
        close_test("reset quiet");

        fetch_one(32'h0000_1040, 1'b1);   // Four cold lines in sets 1, 2, 3 and 15.
        fetch_one(32'h0002_3084, 1'b1);
        fetch_one(32'h1234_50C8, 1'b1);
        fetch_one(32'hFFFF_F3FC, 1'b1);
        close_test("cold misses");

        fetch_one(32'h0000_107C, 1'b0);
        fetch_one(32'h0002_30B0, 1'b0);
        fetch_one(32'h1234_50C0, 1'b0);
        fetch_one(32'hFFFF_F3C0, 1'b0);
        close_test("single hits");

        fetch_burst(32'h0000_1040, WORDS_PER_LINE);
        close_test("back-to-back hits");

        // Both addresses map to set 40 with different tags.
        for (int i = 0; i < 3; i++)
        begin
            fetch_one(32'h0000_5A00, 1'b1);
            fetch_one(32'h0007_9A10, 1'b1);
        end
        close_test("set conflict");

        pulse_flush();
        fetch_one(32'h0002_3088, 1'b1);
        fetch_one(32'h0002_308C, 1'b0);
        close_test("flush");

        repeat (4) @(posedge clk);
        $display("Tests run: %0d, failed checks: %0d", test_count, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* all.f */
rtl/icache_geom_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_data_array.sv
rtl/icache_tag_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
dv/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - rtl/icache_geom_pkg.sv
      - rtl/icache_ctrl_pkg.sv
      - rtl/icache_data_array.sv
      - rtl/icache_tag_array.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - dv/icache_tb.sv
